/* list.f */
+incdir+logic
logic/cpuPkg.sv
logic/stageLinks.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/mipsCore.sv
test/coreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module coreTb -Mdir obj_dir
./obj_dir/VcoreTb | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

/* test/coreTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

module coreTb;
    localparam int MaxSteps  = 64;
    localparam int ModeSkip  = 0;
    localparam int ModeNone  = 1;
    localparam int ModeWrite = 2;
    localparam int ModeStore = 3;

    logic                   clk = 1'b0;
    logic                   rstN = 1'b0;
    logic [`WORD_W-1:0]     instrAddr;
    logic [`WORD_W-1:0]     instrData = '0;
    logic [`WORD_W-1:0]     dataAddr;
    logic [`WORD_W-1:0]     dataWdata;
    logic                   dataWe;
    logic [`WORD_W-1:0]     dataRdata = '0;
    logic                   regWe;
    logic [`REG_ADDR_W-1:0] regAddr;
    logic [`WORD_W-1:0]     regWdata;
    logic [`WORD_W-1:0]     wbPc;

    logic [`WORD_W-1:0] imem [MaxSteps];
    logic [`WORD_W-1:0] dmem [64];

    // Program table in execution order, skipped words included
    logic [`WORD_W-1:0] stepPc   [MaxSteps];
    logic [`WORD_W-1:0] stepWord [MaxSteps];
    int                 stepMode [MaxSteps];
    logic [`WORD_W-1:0] stepA    [MaxSteps];
    logic [`WORD_W-1:0] stepB    [MaxSteps];
    int                 stepCount = 0;

    int writeList[$];
    int storeList[$];
    int storeIdx;
    int valueErrors = 0;
    int otherErrors = 0;

    mipsCore uut (
        .clk, .rstN, .instrAddr, .instrData, .dataAddr, .dataWdata, .dataWe,
        .dataRdata, .regWe, .regAddr, .regWdata, .wbPc
    );

    always #2 clk = ~clk;

    // Mode write: a is the register, b the value. Mode store: a is the address, b the data
    task automatic addStep(input logic [`WORD_W-1:0] pc, input logic [`WORD_W-1:0] word,
                           input int mode, input logic [`WORD_W-1:0] a,
                           input logic [`WORD_W-1:0] b);
        stepPc[stepCount]   = pc;
        stepWord[stepCount] = word;
        stepMode[stepCount] = mode;
        stepA[stepCount]    = a;
        stepB[stepCount]    = b;
        stepCount++;
    endtask

    task automatic checkReg(input string name, input logic [`REG_ADDR_W-1:0] expected,
                            input logic [`REG_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkWord(input string name, input logic [`WORD_W-1:0] expected,
                             input logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory models, answering on the falling edge

    always @(negedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[7:2]] = dataWdata;
        end
        dataRdata = dmem[dataAddr[7:2]];
        if ((instrAddr - `RESET_PC) < 4 * MaxSteps) begin
            instrData = imem[instrAddr[7:2]];
        end else begin
            instrData = '0;
        end
    end

    always @(negedge clk) begin
        if (rstN && dataWe) begin
            if (storeList.size() == 0) begin
                $display("Unexpected store to address %h", dataAddr);
                otherErrors++;
            end else begin
                storeIdx = storeList.pop_front();
                checkWord("store address", stepA[storeIdx], dataAddr);
                checkWord("store data", stepB[storeIdx], dataWdata);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program and expected writebacks

    initial begin
        int idx;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hDA7A_0000 | (i << 2);
            imem[i] = '0;
        end

        // Independent ALU and immediate operations
        addStep(32'h3000, 32'h3C011234, ModeWrite, 1, 32'h12340000);
        addStep(32'h3004, 32'h340200F0, ModeWrite, 2, 32'h000000F0);
        addStep(32'h3008, 32'h2403FFFB, ModeWrite, 3, 32'hFFFFFFFB);
        addStep(32'h300C, 32'h34040F0F, ModeWrite, 4, 32'h00000F0F);
        addStep(32'h3010, 32'h00222821, ModeWrite, 5, 32'h123400F0);
        addStep(32'h3014, 32'h00443023, ModeWrite, 6, 32'hFFFFF1E1);
        addStep(32'h3018, 32'h00833824, ModeWrite, 7, 32'h00000F0B);
        addStep(32'h301C, 32'h00244025, ModeWrite, 8, 32'h12340F0F);
        addStep(32'h3020, 32'h0062482A, ModeWrite, 9, 32'h00000001);
        addStep(32'h3024, 32'h0043502A, ModeWrite, 10, 32'h00000000);
        // Dependent chain
        addStep(32'h3028, 32'h240B0007, ModeWrite, 11, 32'h00000007);
        addStep(32'h302C, 32'h016B6021, ModeWrite, 12, 32'h0000000E);
        addStep(32'h3030, 32'h018B6823, ModeWrite, 13, 32'h00000007);
        addStep(32'h3034, 32'h01AC7025, ModeWrite, 14, 32'h0000000F);
        // Store, load, then load use
        addStep(32'h3038, 32'h240F0040, ModeWrite, 15, 32'h00000040);
        addStep(32'h303C, 32'hADEE0004, ModeStore, 32'h44, 32'h0000000F);
        addStep(32'h3040, 32'h8DF00004, ModeWrite, 16, 32'h0000000F);
        addStep(32'h3044, 32'h02058821, ModeWrite, 17, 32'h123400FF);
        // Branches with delay slots
        addStep(32'h3048, 32'h24120003, ModeWrite, 18, 32'h00000003);
        addStep(32'h304C, 32'h124B0002, ModeNone, 0, 0);
        addStep(32'h3050, 32'h24130001, ModeWrite, 19, 32'h00000001);
        addStep(32'h3054, 32'h24140002, ModeWrite, 20, 32'h00000002);
        addStep(32'h3058, 32'h16800002, ModeNone, 0, 0);
        addStep(32'h305C, 32'h24150005, ModeWrite, 21, 32'h00000005);
        addStep(32'h3060, 32'h24160099, ModeSkip, 0, 0);
        addStep(32'h3064, 32'h12B50002, ModeNone, 0, 0);
        addStep(32'h3068, 32'h02B4B823, ModeWrite, 23, 32'h00000003);
        addStep(32'h306C, 32'h24160077, ModeSkip, 0, 0);
        // Call and return
        addStep(32'h3070, 32'h0C000C24, ModeWrite, 31, 32'h00003078);
        addStep(32'h3074, 32'h24180011, ModeWrite, 24, 32'h00000011);
        addStep(32'h3090, 32'h03E00008, ModeNone, 0, 0);
        addStep(32'h3094, 32'h241A0033, ModeWrite, 26, 32'h00000033);
        addStep(32'h3098, 32'h241B0044, ModeSkip, 0, 0);
        addStep(32'h3078, 32'h24190022, ModeWrite, 25, 32'h00000022);
        addStep(32'h307C, 32'h03F9E021, ModeWrite, 28, 32'h0000309A);
        addStep(32'h3080, 32'h08000C20, ModeNone, 0, 0);
        addStep(32'h3084, 32'h00000000, ModeNone, 0, 0);

        for (int i = 0; i < stepCount; i++) begin
            imem[stepPc[i][7:2]] = stepWord[i];
            if (stepMode[i] == ModeWrite) begin
                writeList.push_back(i);
            end else if (stepMode[i] == ModeStore) begin
                storeList.push_back(i);
            end
        end

        repeat (8) @(negedge clk);

        // Empty pipe and start address while in reset
        checkWord("reset pc", `RESET_PC, instrAddr);
        if (regWe || dataWe) begin
            $display("Write strobe high during reset");
            otherErrors++;
        end
        rstN = 1'b1;

        foreach (writeList[k]) begin
            idx = writeList[k];
            do @(negedge clk); while (!regWe);
            checkReg($sformatf("write %0d address", k), stepA[idx][`REG_ADDR_W-1:0], regAddr);
            checkWord($sformatf("write %0d value", k), stepB[idx], regWdata);
            checkWord($sformatf("write %0d pc", k), stepPc[idx], wbPc);
        end

        // Nothing more may write back
        repeat (12) begin
            @(negedge clk);
            if (regWe) begin
                $display("Unexpected write to register %0d from pc %h", regAddr, wbPc);
                otherErrors++;
            end
        end
        if (storeList.size() != 0) begin
            $display("A store never reached the data port");
            otherErrors++;
        end

        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        @(posedge rstN);
        repeat (stepCount * 4 + 40) @(posedge clk);
        $display("Watchdog expired, register writebacks went missing");
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors + 1);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

module mipsCore (
    input  logic                   clk,
    input  logic                   rstN,
    output logic [`WORD_W-1:0]     instrAddr,
    input  logic [`WORD_W-1:0]     instrData,
    output logic [`WORD_W-1:0]     dataAddr,
    output logic [`WORD_W-1:0]     dataWdata,
    output logic                   dataWe,
    input  logic [`WORD_W-1:0]     dataRdata,
    output logic                   regWe,
    output logic [`REG_ADDR_W-1:0] regAddr,
    output logic [`WORD_W-1:0]     regWdata,
    output logic [`WORD_W-1:0]     wbPc
);
    import cpuPkg::*;

    instrWord           instr;
    logic [`WORD_W-1:0] pcPlus4;
    logic               stall;
    logic               takeBranch;
    logic [`WORD_W-1:0] branchTarget;

    decExLink decEx ();
    exMemLink exMem ();
    wbLink    wb ();

    fetchStage fetch (
        .clk, .rstN, .stall, .takeBranch, .branchTarget,
        .instrData, .instrAddr, .instr, .pcPlus4
    );

    decodeStage decode (
        .clk, .rstN, .instr, .pcPlus4, .stall, .takeBranch, .branchTarget,
        .decEx(decEx), .exMem(exMem), .wb(wb)
    );

    executeStage execute (.clk, .rstN, .decEx(decEx), .exMem(exMem), .wb(wb));

    memoryStage memAccess (
        .clk, .rstN, .dataRdata, .dataAddr, .dataWdata, .dataWe,
        .exMem(exMem), .wb(wb)
    );

    assign regWe    = wb.regWe;
    assign regAddr  = wb.regAddr;
    assign regWdata = wb.regWdata;
    assign wbPc     = wb.pc;

endmodule

`default_nettype wire

/* logic/memoryStage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

module memoryStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic [`WORD_W-1:0] dataRdata,
    output logic [`WORD_W-1:0] dataAddr,
    output logic [`WORD_W-1:0] dataWdata,
    output logic               dataWe,
    exMemLink.sink             exMem,
    wbLink.src                 wb
);
    logic [`WORD_W-1:0] wbValue;

    assign dataAddr  = exMem.result;
    assign dataWdata = exMem.storeData;
    assign dataWe    = exMem.memWrite;

    // Load data or the execute result
    assign wbValue = exMem.memRead ? dataRdata : exMem.result;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb.regWe <= 1'b0;
        end else begin
            wb.regWe <= exMem.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wb.regAddr  <= exMem.dest;
        wb.regWdata <= wbValue;
        wb.pc       <= exMem.pc;
    end

    wordAligned: assert property (@(posedge clk) disable iff (!rstN)
        (exMem.memRead || exMem.memWrite) |-> (exMem.result[1:0] == 2'b00));

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

module executeStage (
    input logic    clk,
    input logic    rstN,
    decExLink.sink decEx,
    exMemLink.src  exMem,
    wbLink.fwd     wb
);
    logic [`WORD_W-1:0] opA;
    logic [`WORD_W-1:0] opB;
    logic [`WORD_W-1:0] aluB;
    logic [`WORD_W-1:0] aluOut;
    logic [`WORD_W-1:0] result;

    // Memory stage first, then writeback, then the value read in decode
    function automatic logic [`WORD_W-1:0] pickOperand(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`WORD_W-1:0]     decoded
    );
        if (exMem.regWrite && exMem.dest == src) begin
            return exMem.result;
        end else if (wb.regWe && wb.regAddr == src) begin
            return wb.regWdata;
        end
        return decoded;
    endfunction

    always_comb begin
        opA = pickOperand(decEx.srcA, decEx.opA);
        opB = pickOperand(decEx.srcB, decEx.opB);
    end

    assign aluB = decEx.useImm ? decEx.imm : opB;

    //////////////////////////////////////////////////////////////////////
    // ALU

    always_comb begin
        case (decEx.aluOp)
            `ALU_SUB: aluOut = opA - aluB;
            `ALU_AND: aluOut = opA & aluB;
            `ALU_OR:  aluOut = opA | aluB;
            `ALU_SLT: aluOut = {{(`WORD_W-1){1'b0}}, $signed(opA) < $signed(aluB)};
            `ALU_LUI: aluOut = {aluB[15:0], 16'b0};
            default:  aluOut = opA + aluB;
        endcase
    end

    // A nonzero link value only comes from jal
    assign result = (decEx.linkValue != '0) ? decEx.linkValue : aluOut;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.regWrite <= decEx.regWrite;
            exMem.memRead  <= decEx.memRead;
            exMem.memWrite <= decEx.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.result    <= result;
        exMem.storeData <= opB;
        exMem.dest      <= decEx.dest;
        exMem.pc        <= decEx.pc;
    end

    noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(exMem.memRead && exMem.memWrite));

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

module decodeStage (
    input  logic               clk,
    input  logic               rstN,
    input  cpuPkg::instrWord   instr,
    input  logic [`WORD_W-1:0] pcPlus4,
    output logic               stall,
    output logic               takeBranch,
    output logic [`WORD_W-1:0] branchTarget,
    decExLink.src              decEx,
    exMemLink.hazard           exMem,
    wbLink.sink                wb
);
    logic [`WORD_W-1:0]     regFile [2**`REG_ADDR_W];
    logic [`REG_ADDR_W-1:0] rsAddr;
    logic [`REG_ADDR_W-1:0] rtAddr;
    logic [`WORD_W-1:0]     rsRead;
    logic [`WORD_W-1:0]     rtRead;
    logic [`WORD_W-1:0]     rsVal;
    logic [`WORD_W-1:0]     rtVal;
    logic [`WORD_W-1:0]     signImm;
    logic [`WORD_W-1:0]     immD;
    logic [`REG_ADDR_W-1:0] destD;
    logic [`ALU_OP_W-1:0]   aluOpD;
    logic                   useRs;
    logic                   useRt;
    logic                   useImmD;
    logic                   memReadD;
    logic                   memWriteD;
    logic                   writesD;
    logic                   isBeq;
    logic                   isBne;
    logic                   isJump;
    logic                   isJal;
    logic                   isJr;
    logic                   exHitRs;
    logic                   exHitRt;
    logic                   memLoadHit;

    assign rsAddr  = instr.rView.rs;
    assign rtAddr  = instr.rView.rt;
    assign signImm = {{16{instr.iView.imm[15]}}, instr.iView.imm};

    //////////////////////////////////////////////////////////////////////
    // Register file, written through from writeback

    always_ff @(posedge clk) begin
        if (wb.regWe) begin
            regFile[wb.regAddr] <= wb.regWdata;
        end
    end

    assign rsRead = (rsAddr == '0) ? '0 :
                    (wb.regWe && wb.regAddr == rsAddr) ? wb.regWdata : regFile[rsAddr];
    assign rtRead = (rtAddr == '0) ? '0 :
                    (wb.regWe && wb.regAddr == rtAddr) ? wb.regWdata : regFile[rtAddr];

    //////////////////////////////////////////////////////////////////////
    // Instruction decode

    always_comb begin
        aluOpD    = `ALU_ADD;
        immD      = signImm;
        destD     = instr.iView.rt;
        useRs     = 1'b0;
        useRt     = 1'b0;
        useImmD   = 1'b0;
        memReadD  = 1'b0;
        memWriteD = 1'b0;
        writesD   = 1'b0;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJump    = 1'b0;
        isJal     = 1'b0;
        isJr      = 1'b0;
        case (instr.rView.op)
            `OP_RTYPE: begin
                destD   = instr.rView.rd;
                useRs   = 1'b1;
                useRt   = 1'b1;
                writesD = 1'b1;
                case (instr.rView.funct)
                    `FN_ADDU: aluOpD = `ALU_ADD;
                    `FN_SUBU: aluOpD = `ALU_SUB;
                    `FN_AND:  aluOpD = `ALU_AND;
                    `FN_OR:   aluOpD = `ALU_OR;
                    `FN_SLT:  aluOpD = `ALU_SLT;
                    `FN_JR: begin
                        isJr    = 1'b1;
                        useRt   = 1'b0;
                        writesD = 1'b0;
                    end
                    default: begin
                        // Unknown function code, runs as a no-op
                        useRs   = 1'b0;
                        useRt   = 1'b0;
                        writesD = 1'b0;
                    end
                endcase
            end
            `OP_ORI, `OP_ADDIU, `OP_LW: begin
                aluOpD   = (instr.iView.op == `OP_ORI) ? `ALU_OR : `ALU_ADD;
                immD     = (instr.iView.op == `OP_ORI) ? {16'b0, instr.iView.imm} : signImm;
                useRs    = 1'b1;
                useImmD  = 1'b1;
                memReadD = (instr.iView.op == `OP_LW);
                writesD  = 1'b1;
            end
            `OP_LUI: begin
                aluOpD  = `ALU_LUI;
                useImmD = 1'b1;
                writesD = 1'b1;
            end
            `OP_SW: begin
                useRs     = 1'b1;
                useRt     = 1'b1;
                useImmD   = 1'b1;
                memWriteD = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                useRs = 1'b1;
                useRt = 1'b1;
                isBeq = (instr.iView.op == `OP_BEQ);
                isBne = (instr.iView.op == `OP_BNE);
            end
            `OP_J:   isJump = 1'b1;
            `OP_JAL: begin
                isJal   = 1'b1;
                destD   = `LINK_REG;
                writesD = 1'b1;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Hazards and branch resolution

    assign exHitRs = decEx.regWrite && useRs && decEx.dest == rsAddr;
    assign exHitRt = decEx.regWrite && useRt && decEx.dest == rtAddr;
    assign memLoadHit = exMem.memRead && exMem.regWrite &&
                        ((useRs && exMem.dest == rsAddr) || (useRt && exMem.dest == rtAddr));

    // Loads stall their users; branches also wait on anything in execute
    assign stall = (decEx.memRead && (exHitRs || exHitRt)) ||
                   ((isBeq || isBne || isJr) && (exHitRs || exHitRt || memLoadHit));

    assign rsVal = (exMem.regWrite && !exMem.memRead && exMem.dest == rsAddr) ?
                   exMem.result : rsRead;
    assign rtVal = (exMem.regWrite && !exMem.memRead && exMem.dest == rtAddr) ?
                   exMem.result : rtRead;

    assign takeBranch = !stall && (isJump || isJal || isJr ||
                                   (isBeq && rsVal == rtVal) || (isBne && rsVal != rtVal));

    always_comb begin
        if (isJr) begin
            branchTarget = rsVal;
        end else if (isJump || isJal) begin
            branchTarget = {pcPlus4[31:28], instr.jView.target, 2'b00};
        end else begin
            branchTarget = pcPlus4 + {signImm[`WORD_W-3:0], 2'b00};
        end
    end

    // Bubble on stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decEx.regWrite <= 1'b0;
            decEx.memRead  <= 1'b0;
            decEx.memWrite <= 1'b0;
        end else begin
            decEx.regWrite <= !stall && writesD && destD != '0;
            decEx.memRead  <= !stall && memReadD;
            decEx.memWrite <= !stall && memWriteD;
        end
    end

    always_ff @(posedge clk) begin
        decEx.opA       <= rsRead;
        decEx.opB       <= rtRead;
        decEx.srcA      <= useRs ? rsAddr : '0;
        decEx.srcB      <= useRt ? rtAddr : '0;
        decEx.imm       <= immD;
        decEx.dest      <= destD;
        decEx.aluOp     <= aluOpD;
        decEx.useImm    <= useImmD;
        decEx.linkValue <= isJal ? pcPlus4 + 4 : '0;
        decEx.pc        <= pcPlus4 - 4;
    end

    // A hazard stall clears within two cycles
    stallBounded: assert property (@(posedge clk) disable iff (!rstN)
        (stall && $past(stall)) |-> !$past(stall, 2));

endmodule

`default_nettype wire

/* logic/fetchStage.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

module fetchStage (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stall,
    input  logic               takeBranch,
    input  logic [`WORD_W-1:0] branchTarget,
    input  logic [`WORD_W-1:0] instrData,
    output logic [`WORD_W-1:0] instrAddr,
    output cpuPkg::instrWord   instr,
    output logic [`WORD_W-1:0] pcPlus4
);
    logic [`WORD_W-1:0] pc;
    logic [`WORD_W-1:0] seqPc;

    assign seqPc     = pc + 4;
    assign instrAddr = pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= takeBranch ? branchTarget : seqPc;
        end
    end

    // The word fetched beside a branch is its delay slot, never flushed
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instr   <= '0;
            pcPlus4 <= `RESET_PC;
        end else if (!stall) begin
            instr   <= instrData;
            pcPlus4 <= seqPc;
        end
    end

endmodule

`default_nettype wire

/* logic/stageLinks.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cpu_macros.svh"

// Decode to execute
interface decExLink;
    logic [`WORD_W-1:0]     opA;
    logic [`WORD_W-1:0]     opB;
    logic [`REG_ADDR_W-1:0] srcA;
    logic [`REG_ADDR_W-1:0] srcB;
    logic [`WORD_W-1:0]     imm;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`ALU_OP_W-1:0]   aluOp;
    logic                   useImm;
    logic                   memRead;
    logic                   memWrite;
    logic                   regWrite;
    logic [`WORD_W-1:0]     linkValue;
    logic [`WORD_W-1:0]     pc;

    modport src (output opA, opB, srcA, srcB, imm, dest, aluOp, useImm,
                 memRead, memWrite, regWrite, linkValue, pc);
    modport sink (input opA, opB, srcA, srcB, imm, dest, aluOp, useImm,
                  memRead, memWrite, regWrite, linkValue, pc);
endinterface

// Execute to memory, also watched by decode for hazards
interface exMemLink;
    logic [`WORD_W-1:0]     result;
    logic [`WORD_W-1:0]     storeData;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   memRead;
    logic                   memWrite;
    logic                   regWrite;
    logic [`WORD_W-1:0]     pc;

    modport src (output result, storeData, dest, memRead, memWrite, regWrite, pc);
    modport sink (input result, storeData, dest, memRead, memWrite, regWrite, pc);
    modport hazard (input result, dest, memRead, regWrite);
endinterface

interface wbLink;
    logic                   regWe;
    logic [`REG_ADDR_W-1:0] regAddr;
    logic [`WORD_W-1:0]     regWdata;
    logic [`WORD_W-1:0]     pc;

    modport src (output regWe, regAddr, regWdata, pc);
    modport sink (input regWe, regAddr, regWdata);
    modport fwd (input regWe, regAddr, regWdata);
endinterface

`default_nettype wire

/* logic/cpuPkg.sv */
`default_nettype none
`include "cpu_macros.svh"

package cpuPkg;

    // One instruction word, read as R, I or J format
    typedef union packed {
        struct packed {
            logic [5:0]             op;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [`REG_ADDR_W-1:0] rd;
            logic [4:0]             shamt;
            logic [5:0]             funct;
        } rView;
        struct packed {
            logic [5:0]             op;
            logic [`REG_ADDR_W-1:0] rs;
            logic [`REG_ADDR_W-1:0] rt;
            logic [15:0]            imm;
        } iView;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } jView;
    } instrWord;

endpackage

`default_nettype wire

/* logic/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define ALU_OP_W    3

`define RESET_PC    32'h0000_3000
`define LINK_REG    5'd31

// Primary opcodes
`define OP_RTYPE    6'h00
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// R-type function codes
`define FN_JR       6'h08
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

`define ALU_ADD     3'd0
`define ALU_SUB     3'd1
`define ALU_AND     3'd2
`define ALU_OR      3'd3
`define ALU_SLT     3'd4
`define ALU_LUI     3'd5

`endif
